/* flist.f */
logic/ex_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/ex_stage.sv
logic/ex_top.sv
tb/ex_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - logic/ex_pkg.sv
  - logic/alu.sv
  - logic/reg_file.sv
  - logic/ex_stage.sv
  - logic/ex_top.sv
  - target: simulation
    files:
      - tb/ex_tb.sv

/* tb/ex_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_tb;

	localparam int DATA_W = 64;
	// cycles allowed for outstanding results to appear
	localparam int drain_limit = 40;

	// one expected result per issued instruction
	typedef struct packed {
		logic [DATA_W-1:0]  result;
		logic [DATA_W-1:0]  rd2;
		logic [DATA_W-1:0]  target;
		ex_pkg::alu_flags_t flags;
	} expect_t;

	logic               clk;
	logic               rst_n;
	logic               issue;
	ex_pkg::ex_ctrl_t   ctrl;
	logic [DATA_W-1:0]  imm;
	logic [DATA_W-1:0]  pc;
	logic [DATA_W-1:0]  br_offset;
	logic               valid;
	logic [DATA_W-1:0]  alu_result;
	logic [DATA_W-1:0]  rd2_out;
	logic [DATA_W-1:0]  br_target;
	ex_pkg::alu_flags_t flags;

	// register and flag model, x31 is never written
	logic [DATA_W-1:0]  model_regs [0:31];
	ex_pkg::alu_flags_t model_flags;
	expect_t            expect_q [$];
	integer             seed;
	int                 checks;
	int                 errors;
	int                 test_base;
	string              cur_test;
	ex_pkg::alu_op_e    op_list [6] = '{ex_pkg::op_pass_b, ex_pkg::op_add, ex_pkg::op_sub,
		ex_pkg::op_and, ex_pkg::op_or, ex_pkg::op_xor};

	ex_top #(
		.DATA_W(DATA_W)
	) uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.ctrl       (ctrl),
		.imm        (imm),
		.pc         (pc),
		.br_offset  (br_offset),
		.valid      (valid),
		.alu_result (alu_result),
		.rd2_out    (rd2_out),
		.br_target  (br_target),
		.flags      (flags)
	);

	// 20 ns period
	always #10 clk = ~clk;

	// expected {n, z, v, c, result}
	// carry on subtract means no borrow
	function automatic logic [DATA_W+3:0] ref_alu(input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b, input ex_pkg::alu_op_e op);
		logic [DATA_W-1:0] r;
		logic              c;
		logic              v;
		c = 1'b0;
		v = 1'b0;
		case (op)
			ex_pkg::op_add: begin
				{c, r} = {1'b0, a} + {1'b0, b};
				v = (a[DATA_W-1] == b[DATA_W-1]) && (r[DATA_W-1] != a[DATA_W-1]);
			end
			ex_pkg::op_sub: begin
				r = a - b;
				c = (a >= b);
				v = (a[DATA_W-1] != b[DATA_W-1]) && (r[DATA_W-1] != a[DATA_W-1]);
			end
			ex_pkg::op_and: r = a & b;
			ex_pkg::op_or:  r = a | b;
			ex_pkg::op_xor: r = a ^ b;
			default:        r = b;
		endcase
		return {r[DATA_W-1], (r == '0), v, c, r};
	endfunction

	function automatic logic [DATA_W-1:0] rand64();
		logic [DATA_W-1:0] v;
		v[63:32] = $random(seed);
		v[31:0]  = $random(seed);
		return v;
	endfunction

	function automatic ex_pkg::ex_ctrl_t make_ctrl(input ex_pkg::alu_op_e op, input logic src,
		input logic sf, input logic rw, input logic [4:0] rn, input logic [4:0] rm,
		input logic [4:0] rd);
		ex_pkg::ex_ctrl_t c;
		c = '0;
		c.alu_op    = op;
		c.alu_src   = src;
		c.set_flags = sf;
		c.reg_write = rw;
		c.rn        = rn;
		c.rm        = rm;
		c.rd        = rd;
		return c;
	endfunction

	task automatic compare_value(input string field, input logic [DATA_W-1:0] exp_v,
		input logic [DATA_W-1:0] act_v);
		checks++;
		assert (act_v === exp_v) else begin
			$display("ERROR %s %s expected %h actual %h", cur_test, field, exp_v, act_v);
			errors++;
		end
	endtask

	// update the model, queue the expectation, then drive the instruction
	task automatic issue_instr(input ex_pkg::ex_ctrl_t c, input logic [DATA_W-1:0] imm_v,
		input logic [DATA_W-1:0] pc_v, input logic [DATA_W-1:0] off_v);
		logic [DATA_W-1:0] rs2;
		logic [DATA_W+3:0] r;
		expect_t           e;
		rs2 = model_regs[c.rm];
		r   = ref_alu(model_regs[c.rn], c.alu_src ? imm_v : rs2, c.alu_op);
		if (c.set_flags)
			model_flags = r[DATA_W+3:DATA_W];
		if (c.reg_write && c.rd != 5'd31)
			model_regs[c.rd] = r[DATA_W-1:0];
		e.result = r[DATA_W-1:0];
		e.rd2    = rs2;
		e.target = pc_v + off_v * 4;
		e.flags  = model_flags;
		expect_q.push_back(e);
		@(posedge clk);
		issue     <= 1'b1;
		ctrl      <= c;
		imm       <= imm_v;
		pc        <= pc_v;
		br_offset <= off_v;
	endtask

	task automatic load_reg(input logic [4:0] rd, input logic [DATA_W-1:0] val);
		issue_instr(make_ctrl(ex_pkg::op_pass_b, 1'b1, 1'b0, 1'b1, 5'd0, 5'd0, rd), val, '0, '0);
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_base = errors;
	endtask

	// stop issuing, wait for all results, then print the test line
	task automatic finish_test();
		int cycles;
		cycles = 0;
		@(posedge clk);
		issue <= 1'b0;
		while (expect_q.size() != 0 && cycles < drain_limit) begin
			@(posedge clk);
			cycles++;
		end
		if (expect_q.size() != 0) begin
			$display("%s timed out with %0d results never delivered", cur_test, expect_q.size());
			errors++;
			expect_q.delete();
		end
		$display("test %-10s %0d errors", cur_test, errors - test_base);
	endtask

	// sampled on the falling edge where outputs are settled
	always @(negedge clk) begin
		expect_t e;
		if (rst_n && valid) begin
			if (expect_q.size() == 0) begin
				$display("%s saw valid with no instruction outstanding", cur_test);
				errors++;
			end else begin
				e = expect_q.pop_front();
				compare_value("alu_result", e.result, alu_result);
				compare_value("rd2_out", e.rd2, rd2_out);
				compare_value("br_target", e.target, br_target);
				compare_value("flags", e.flags, flags);
			end
		end
	end

	initial begin
		logic [4:0] rd;
		logic [4:0] prev_rd;
		logic [31:0] r32;
		clk = 1'b0;
		seed = 17;
		checks = 0;
		errors = 0;
		model_flags = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		rst_n <= 1'b0;
		issue <= 1'b0;
		ctrl <= '0;
		imm <= '0;
		pc <= '0;
		br_offset <= '0;
		start_test("reset");
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		compare_value("valid", '0, valid);
		compare_value("flags", '0, flags);
		compare_value("alu_result", '0, alu_result);
		compare_value("br_target", '0, br_target);
		finish_test();

		// load every register, then dependent register-register ops
		start_test("reg_reg");
		for (int i = 0; i < 31; i++)
			load_reg(i[4:0], rand64());
		prev_rd = 5'd0;
		for (int i = 0; i < 60; i++) begin
			r32 = $random(seed);
			rd = r32[4:0];
			issue_instr(make_ctrl(op_list[i % 6], 1'b0, r32[5], 1'b1,
				r32[6] ? prev_rd : r32[11:7], r32[16:12], rd), rand64(), rand64(), rand64());
			prev_rd = rd;
		end
		finish_test();

		// corner values for carry, overflow, negative and zero
		start_test("immediate");
		load_reg(5'd1, 64'h7fff_ffff_ffff_ffff);
		load_reg(5'd2, '1);
		load_reg(5'd3, 64'd5);
		load_reg(5'd4, '0);
		load_reg(5'd5, 64'h8000_0000_0000_0000);
		issue_instr(make_ctrl(ex_pkg::op_add, 1'b1, 1'b1, 1'b1, 5'd1, 5'd0, 5'd10), 64'd1, '0, '0);
		issue_instr(make_ctrl(ex_pkg::op_add, 1'b1, 1'b1, 1'b1, 5'd2, 5'd0, 5'd11), 64'd1, '0, '0);
		issue_instr(make_ctrl(ex_pkg::op_sub, 1'b1, 1'b1, 1'b1, 5'd3, 5'd0, 5'd12), 64'd5, '0, '0);
		issue_instr(make_ctrl(ex_pkg::op_sub, 1'b1, 1'b1, 1'b1, 5'd4, 5'd0, 5'd13), 64'd1, '0, '0);
		issue_instr(make_ctrl(ex_pkg::op_sub, 1'b1, 1'b1, 1'b1, 5'd5, 5'd0, 5'd14), 64'd1, '0, '0);
		for (int i = 0; i < 18; i++) begin
			r32 = $random(seed);
			issue_instr(make_ctrl(op_list[i % 6], 1'b1, 1'b1, 1'b1, r32[4:0], r32[9:5],
				r32[14:10]), rand64(), rand64(), rand64());
		end
		finish_test();

		// set zero and carry, then hold them through random ops
		start_test("flag_hold");
		load_reg(5'd3, 64'd5);
		load_reg(5'd4, '0);
		issue_instr(make_ctrl(ex_pkg::op_sub, 1'b1, 1'b1, 1'b0, 5'd3, 5'd0, 5'd0), 64'd5, '0, '0);
		for (int i = 0; i < 12; i++) begin
			r32 = $random(seed);
			issue_instr(make_ctrl(op_list[i % 6], r32[15], 1'b0, 1'b1, r32[4:0], r32[9:5],
				r32[14:10]), rand64(), rand64(), rand64());
		end
		issue_instr(make_ctrl(ex_pkg::op_sub, 1'b1, 1'b1, 1'b0, 5'd4, 5'd0, 5'd0), 64'd1, '0, '0);
		finish_test();

		start_test("branch");
		for (int i = 0; i < 20; i++)
			issue_instr(make_ctrl(ex_pkg::op_pass_b, 1'b0, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0),
				'0, rand64(), rand64());
		finish_test();

		// a write to x31 must not stick
		start_test("zero_reg");
		load_reg(5'd31, 64'hdead_beef_0123_4567);
		issue_instr(make_ctrl(ex_pkg::op_add, 1'b0, 1'b1, 1'b1, 5'd31, 5'd31, 5'd6), '1, '0, '0);
		issue_instr(make_ctrl(ex_pkg::op_or, 1'b0, 1'b1, 1'b1, 5'd31, 5'd31, 5'd7), '1, '0, '0);
		issue_instr(make_ctrl(ex_pkg::op_pass_b, 1'b0, 1'b0, 1'b1, 5'd1, 5'd31, 5'd8), '1, '0, '0);
		finish_test();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/ex_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_top #(
	parameter int DATA_W = 64
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   issue,
	input  wire ex_pkg::ex_ctrl_t ctrl,
	input  wire [DATA_W-1:0]      imm,
	input  wire [DATA_W-1:0]      pc,
	input  wire [DATA_W-1:0]      br_offset,
	output logic                  valid,
	output logic [DATA_W-1:0]     alu_result,
	output logic [DATA_W-1:0]     rd2_out,
	output logic [DATA_W-1:0]     br_target,
	output ex_pkg::alu_flags_t    flags
);

	// register read values for rn and rm
	logic [DATA_W-1:0] rd_data1;
	logic [DATA_W-1:0] rd_data2;
	// write back from the execute stage
	logic [DATA_W-1:0] wb_data;
	logic              wb_en;

	// reads are driven straight from the issued fields
	reg_file #(
		.DATA_W(DATA_W)
	) u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_addr1 (ctrl.rn),
		.rd_addr2 (ctrl.rm),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.wr_en    (wb_en),
		.wr_addr  (ctrl.rd),
		.wr_data  (wb_data)
	);

	ex_stage #(
		.DATA_W(DATA_W)
	) u_ex_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.ctrl       (ctrl),
		.rs1_data   (rd_data1),
		.rs2_data   (rd_data2),
		.imm        (imm),
		.pc         (pc),
		.br_offset  (br_offset),
		.wb_data    (wb_data),
		.wb_en      (wb_en),
		.valid      (valid),
		.alu_result (alu_result),
		.rd2_out    (rd2_out),
		.br_target  (br_target),
		.flags      (flags)
	);

endmodule

`default_nettype wire

/* logic/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
	parameter int DATA_W = 64
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   issue,
	input  wire ex_pkg::ex_ctrl_t ctrl,
	input  wire [DATA_W-1:0]      rs1_data,
	input  wire [DATA_W-1:0]      rs2_data,
	input  wire [DATA_W-1:0]      imm,
	input  wire [DATA_W-1:0]      pc,
	input  wire [DATA_W-1:0]      br_offset,
	output logic [DATA_W-1:0]     wb_data,
	output logic                  wb_en,
	output logic                  valid,
	output logic [DATA_W-1:0]     alu_result,
	output logic [DATA_W-1:0]     rd2_out,
	output logic [DATA_W-1:0]     br_target,
	output ex_pkg::alu_flags_t    flags
);

	// second alu operand
	logic [DATA_W-1:0]  op_b;
	// pc relative branch target before the latch
	logic [DATA_W-1:0]  target;
	// flags straight from the alu
	ex_pkg::alu_flags_t alu_flags;

	// immediate or register for operand b
	assign op_b = ctrl.alu_src ? imm : rs2_data;

	alu #(
		.DATA_W(DATA_W)
	) u_alu (
		.a      (rs1_data),
		.b      (op_b),
		.op     (ctrl.alu_op),
		.result (wb_data),
		.flags  (alu_flags)
	);

	// offset is in words so scale by four
	assign target = pc + (br_offset << 2);

	// write back happens this cycle so the next issue sees it
	assign wb_en = issue & ctrl.reg_write;

	// output latch with one cycle of latency
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid      <= 1'b0;
			alu_result <= '0;
			rd2_out    <= '0;
			br_target  <= '0;
		end else begin
			valid <= issue;
			if (issue) begin
				alu_result <= wb_data;
				// store data path for a later memory stage
				rd2_out    <= rs2_data;
				br_target  <= target;
			end
		end
	end

	// flag register
	// holds unless the instruction asks for an update
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags <= '0;
		end else if (issue && ctrl.set_flags) begin
			flags <= alu_flags;
		end
	end

	// without a new issue valid drops after one cycle
	valid_one_cycle : assert property (@(posedge clk) disable iff (!rst_n)
		(valid && !issue) |=> !valid)
		else $error("valid held without issue");

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
	parameter int DATA_W = 64
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire ex_pkg::reg_addr_t rd_addr1,
	input  wire ex_pkg::reg_addr_t rd_addr2,
	output logic [DATA_W-1:0]     rd_data1,
	output logic [DATA_W-1:0]     rd_data2,
	input  wire                   wr_en,
	input  wire ex_pkg::reg_addr_t wr_addr,
	input  wire [DATA_W-1:0]      wr_data
);

	// x0..x30 are real storage
	localparam int num_regs = 31;

	logic [DATA_W-1:0] regs [0:num_regs-1];

	// single write port, writes to x31 dropped
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != ex_pkg::zero_reg)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// combinational reads
	// no bypass needed since a write lands before the next issue reads
	always_comb begin
		rd_data1 = (rd_addr1 == ex_pkg::zero_reg) ? '0 : regs[rd_addr1];
		rd_data2 = (rd_addr2 == ex_pkg::zero_reg) ? '0 : regs[rd_addr2];
	end

	// a write aimed at x31 leaves it reading zero afterwards
	zero_reg_port1 : assert property (@(posedge clk) disable iff (!rst_n)
		(wr_en && (wr_addr == ex_pkg::zero_reg)) ##1 (rd_addr1 == ex_pkg::zero_reg)
		|-> (rd_data1 == '0))
		else $error("x31 read nonzero on port 1");

	zero_reg_port2 : assert property (@(posedge clk) disable iff (!rst_n)
		(wr_en && (wr_addr == ex_pkg::zero_reg)) ##1 (rd_addr2 == ex_pkg::zero_reg)
		|-> (rd_data2 == '0))
		else $error("x31 read nonzero on port 2");

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu #(
	parameter int DATA_W = 64
) (
	input  wire [DATA_W-1:0]     a,
	input  wire [DATA_W-1:0]     b,
	input  wire ex_pkg::alu_op_e op,
	output logic [DATA_W-1:0]    result,
	output ex_pkg::alu_flags_t   flags
);

	// adder operand after optional inversion
	logic [DATA_W-1:0] b_eff;
	// high for subtract
	logic              sub;
	// high for add or subtract
	logic              arith;
	// sum with the carry out in the top bit
	logic [DATA_W:0]   sum;

	// one shared adder for add and subtract
	always_comb begin
		sub   = (op == ex_pkg::op_sub);
		arith = sub || (op == ex_pkg::op_add);
		// subtract as a + ~b + 1
		b_eff = sub ? ~b : b;
		sum   = {1'b0, a} + {1'b0, b_eff} + {{DATA_W{1'b0}}, sub};
	end

	// result select
	always_comb begin
		case (op)
			ex_pkg::op_add,
			ex_pkg::op_sub: begin
				result = sum[DATA_W-1:0];
			end
			ex_pkg::op_and: begin
				result = a & b;
			end
			ex_pkg::op_or: begin
				result = a | b;
			end
			ex_pkg::op_xor: begin
				result = a ^ b;
			end
			// pass b and the two unused codes
			default: begin
				result = b;
			end
		endcase
	end

	// flags from the selected result
	always_comb begin
		flags.negative = result[DATA_W-1];
		flags.zero     = ~|result;
		// carry and overflow only mean something for add and subtract
		flags.carry    = arith & sum[DATA_W];
		// operands agree in sign but the sum does not
		flags.overflow = arith
			& (a[DATA_W-1] == b_eff[DATA_W-1])
			& (sum[DATA_W-1] != a[DATA_W-1]);
	end

	// subtract and xor give a zero result exactly when the operands are equal
	always_comb begin
		if ((op == ex_pkg::op_sub) || (op == ex_pkg::op_xor)) begin
			assert final (flags.zero == (a == b))
				else $error("alu zero flag disagrees with operand compare");
		end
	end

endmodule

`default_nettype wire

/* logic/ex_pkg.sv */
`default_nettype none

package ex_pkg;

	// alu operation codes
	// add keeps the legacy 3'b010 encoding
	// codes 001 and 111 are unused and fall through to pass b
	typedef enum logic [2:0] {
		op_pass_b = 3'b000,
		op_add    = 3'b010,
		op_sub    = 3'b011,
		op_and    = 3'b100,
		op_or     = 3'b101,
		op_xor    = 3'b110
	} alu_op_e;

	// register index into the 32 entry file
	typedef logic [4:0] reg_addr_t;

	// x31 is hard wired to zero
	localparam reg_addr_t zero_reg = 5'd31;

	// condition flags in nzvc order
	typedef struct packed {
		logic negative;
		logic zero;
		logic overflow;
		logic carry;
	} alu_flags_t;

	// decoded control for one issued instruction
	// 22 bits with alu_op in the top bits
	typedef struct packed {
		// operation for the alu
		alu_op_e   alu_op;
		// second operand from the immediate instead of rm
		logic      alu_src;
		// load the flag register from this result
		logic      set_flags;
		// write the result back to rd
		logic      reg_write;
		// source and destination registers
		reg_addr_t rn;
		reg_addr_t rm;
		reg_addr_t rd;
		// reserved for later decode use
		logic      spare;
	} ex_ctrl_t;

endpackage

`default_nettype wire
